/* src/app_data_arbiter.sv */
`timescale 1ns/1ps

module app_data_arbiter import shell_pkg::*; (
    input  logic clk,
    input  logic rst_n,

    input  logic app_ip_req,
    input  logic app_ip_rel,
    input  logic app_cpu_req,
    input  logic app_cpu_rel,

    output logic app_ip_grant,
    output logic app_cpu_grant
);

    app_grant_t state;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= GRANT_NONE;
        end else begin
            case (state)
                GRANT_NONE: begin
                    // ip side wins a tie
                    if (app_ip_req) begin
                        state <= GRANT_IP;
                    end else if (app_cpu_req) begin
                        state <= GRANT_CPU;
                    end
                end
                GRANT_IP: begin
                    if (app_ip_rel) begin
                        state <= GRANT_NONE;
                    end
                end
                GRANT_CPU: begin
                    if (app_cpu_rel) begin
                        state <= GRANT_NONE;
                    end
                end
                default: state <= GRANT_NONE;
            endcase
        end
    end

    assign app_ip_grant  = (state == GRANT_IP);
    assign app_cpu_grant = (state == GRANT_CPU);

    a_grant_exclusive: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(app_ip_grant && app_cpu_grant)
    ) else $error("app_data_arbiter: both sides granted");

endmodule

/* src/byte_queue.sv */
`timescale 1ns/1ps

module byte_queue import shell_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,

    input  logic  q_wr,
    input  byte_t q_din,
    output logic  q_full,

    input  logic  q_rd,
    output byte_t q_dout,
    output logic  q_empty
);

    byte_t                      mem [RX_QUEUE_DEPTH];
    logic [RX_QUEUE_AWIDTH-1:0] wr_ptr;
    logic [RX_QUEUE_AWIDTH-1:0] rd_ptr;
    logic [RX_QUEUE_AWIDTH:0]   count;

    logic do_wr;
    logic do_rd;

    // overflowing writes and underflowing reads are dropped
    assign do_wr = q_wr && !q_full;
    assign do_rd = q_rd && !q_empty;

    assign q_full  = (count == (RX_QUEUE_AWIDTH+1)'(RX_QUEUE_DEPTH));
    assign q_empty = (count == '0);

    // head is visible without a read strobe
    assign q_dout = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= q_din;
        end
    end

    // pointers wrap at the natural power of two
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // checks on the writer and the reader
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // writer has to honour back-pressure
    a_no_overflow: assert property (
        @(posedge clk) disable iff (!rst_n)
        q_wr |-> !q_full
    ) else $error("byte_queue: write while full");

    a_no_underflow: assert property (
        @(posedge clk) disable iff (!rst_n)
        q_rd |-> !q_empty
    ) else $error("byte_queue: read while empty");

endmodule

/* src/rxbuf_monitor.sv */
`timescale 1ns/1ps

module rxbuf_monitor import shell_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,

    input  logic      rxbuf_ip_rel,
    output logic      rxbuf_ip_grant,

    input  rxbuf_wr_t rxbuf_wr,

    output logic      led_r,
    output logic      led_g,
    output logic      led_b
);

    buf_owner_t owner;
    logic       rxbuf_cpu_grant;
    logic       rxbuf_cpu_rel;
    rx_size_t   last_rx_size;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // buffer ownership
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            owner <= OWNER_IP;
        end else begin
            case (owner)
                OWNER_IP: begin
                    if (rxbuf_ip_rel) begin
                        owner <= OWNER_CPU;
                    end
                end
                OWNER_CPU: begin
                    if (rxbuf_cpu_rel) begin
                        owner <= OWNER_IP;
                    end
                end
                default: owner <= OWNER_IP;
            endcase
        end
    end

    assign rxbuf_ip_grant  = (owner == OWNER_IP);
    assign rxbuf_cpu_grant = (owner == OWNER_CPU);

    // cpu gives the buffer straight back, one cycle after it sees the grant
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rxbuf_cpu_rel <= 1'b0;
        end else begin
            rxbuf_cpu_rel <= rxbuf_cpu_grant;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // received size and leds
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // snooped regardless of ownership
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            last_rx_size <= '0;
        end else if (rxbuf_wr.we && (rxbuf_wr.addr == RX_SIZE_WORD_ADDR)) begin
            last_rx_size <= rxbuf_wr.wdata[31:16];
        end
    end

    assign led_r = (last_rx_size != '0) && (last_rx_size <= LED_R_MAX);
    assign led_g = (last_rx_size > LED_R_MAX) && (last_rx_size <= LED_G_MAX);
    assign led_b = (last_rx_size > LED_G_MAX);

    a_led_onehot0: assert property (
        @(posedge clk) disable iff (!rst_n)
        $onehot0({led_r, led_g, led_b})
    ) else $error("rxbuf_monitor: more than one led lit");

endmodule

/* src/shell_pkg.sv */
package shell_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // widths and depths
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int TXBUF_AWIDTH    = 6;
    localparam int RXBUF_AWIDTH    = 6;

    localparam int RX_QUEUE_DEPTH  = 16;
    localparam int RX_QUEUE_AWIDTH = 4;

    // release fires when this counter bit goes high, every 33 cycles
    localparam int TX_TIMER_MSB    = 5;

    localparam int TXMSG_LEN       = 5;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // types
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef logic [7:0]              byte_t;
    typedef logic [31:0]             word_t;
    typedef logic [15:0]             rx_size_t;
    typedef logic [TXBUF_AWIDTH-1:0] txbuf_addr_t;
    typedef logic [RXBUF_AWIDTH-1:0] rxbuf_addr_t;

    // write port of the receive buffer as driven by the engine
    typedef struct packed {
        rxbuf_addr_t addr;
        logic        ce;
        logic        we;
        word_t       wdata;
    } rxbuf_wr_t;

    typedef enum logic {
        OWNER_IP  = 1'b0,
        OWNER_CPU = 1'b1
    } buf_owner_t;

    typedef enum logic [1:0] {
        GRANT_NONE = 2'b00,
        GRANT_IP   = 2'b01,
        GRANT_CPU  = 2'b10
    } app_grant_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // constants
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // transmit message: destination ip, ports, length, then payload text
    localparam word_t TXMSG_WORD0 = 32'h0a01a8c0;
    localparam word_t TXMSG_WORD1 = 32'h045704d2;
    localparam word_t TXMSG_WORD2 = 32'h00000007;
    localparam word_t TXMSG_WORD3 = 32'h626f6f66;
    localparam word_t TXMSG_WORD4 = 32'h000a7261;

    // size sits in the upper half of this word
    localparam rxbuf_addr_t RX_SIZE_WORD_ADDR = 6'd1;

    localparam rx_size_t LED_R_MAX = 16'd10;
    localparam rx_size_t LED_G_MAX = 16'd20;

endpackage

/* src/txbuf_msg_source.sv */
`timescale 1ns/1ps

module txbuf_msg_source import shell_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,

    input  logic        txbuf_ip_rel,
    output logic        txbuf_ip_grant,

    input  txbuf_addr_t txbuf_addr,
    output word_t       txbuf_rdata
);

    logic [TX_TIMER_MSB:0] tx_cnt;
    logic                  tx_cpu_rel;
    buf_owner_t            owner;
    word_t                 rom_word;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // periodic cpu release
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tx_cnt     <= '0;
            tx_cpu_rel <= 1'b0;
        end else begin
            if (tx_cnt[TX_TIMER_MSB]) begin
                tx_cpu_rel <= 1'b1;
                tx_cnt     <= '0;
            end else begin
                tx_cpu_rel <= 1'b0;
                tx_cnt     <= tx_cnt + 1'b1;
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // buffer ownership
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // cpu holds the buffer out of reset and hands it over on its release
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            owner <= OWNER_CPU;
        end else begin
            case (owner)
                OWNER_CPU: begin
                    if (tx_cpu_rel) begin
                        owner <= OWNER_IP;
                    end
                end
                OWNER_IP: begin
                    if (txbuf_ip_rel) begin
                        owner <= OWNER_CPU;
                    end
                end
                default: owner <= OWNER_CPU;
            endcase
        end
    end

    assign txbuf_ip_grant = (owner == OWNER_IP);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // message rom
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        rom_word = '0;
        if (txbuf_addr < txbuf_addr_t'(TXMSG_LEN)) begin
            case (txbuf_addr[2:0])
                3'd0:    rom_word = TXMSG_WORD0;
                3'd1:    rom_word = TXMSG_WORD1;
                3'd2:    rom_word = TXMSG_WORD2;
                3'd3:    rom_word = TXMSG_WORD3;
                3'd4:    rom_word = TXMSG_WORD4;
                default: rom_word = '0;
            endcase
        end
    end

    // one cycle read latency, like a block ram
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            txbuf_rdata <= '0;
        end else begin
            txbuf_rdata <= rom_word;
        end
    end

    // the counter stops at its firing value and restarts from zero
    a_timer_wraps: assert property (
        @(posedge clk) disable iff (!rst_n)
        tx_cnt[TX_TIMER_MSB] |-> (tx_cnt[TX_TIMER_MSB-1:0] == '0) ##1 (tx_cnt == '0)
    ) else $error("txbuf_msg_source: release counter overran");

endmodule

/* src/udp_cpu_shell.sv */
`timescale 1ns/1ps

module udp_cpu_shell import shell_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,

    // received payload bytes toward the engine
    input  logic        q_wr,
    input  byte_t       q_din,
    output logic        q_full,
    input  logic        q_rd,
    output byte_t       q_dout,
    output logic        q_empty,

    // udp transmit buffer
    input  logic        txbuf_ip_rel,
    output logic        txbuf_ip_grant,
    input  txbuf_addr_t txbuf_addr,
    output word_t       txbuf_rdata,

    // udp receive buffer
    input  logic        rxbuf_ip_rel,
    output logic        rxbuf_ip_grant,
    input  rxbuf_wr_t   rxbuf_wr,

    output logic        led_r,
    output logic        led_g,
    output logic        led_b,

    // application data block
    input  logic        app_ip_req,
    input  logic        app_ip_rel,
    input  logic        app_cpu_req,
    input  logic        app_cpu_rel,
    output logic        app_ip_grant,
    output logic        app_cpu_grant
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // producer, buffer and consumer around the engine
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    txbuf_msg_source txs0 (
        .clk            (clk),
        .rst_n          (rst_n),
        .txbuf_ip_rel   (txbuf_ip_rel),
        .txbuf_ip_grant (txbuf_ip_grant),
        .txbuf_addr     (txbuf_addr),
        .txbuf_rdata    (txbuf_rdata)
    );

    byte_queue rxq0 (
        .clk     (clk),
        .rst_n   (rst_n),
        .q_wr    (q_wr),
        .q_din   (q_din),
        .q_full  (q_full),
        .q_rd    (q_rd),
        .q_dout  (q_dout),
        .q_empty (q_empty)
    );

    rxbuf_monitor rxm0 (
        .clk            (clk),
        .rst_n          (rst_n),
        .rxbuf_ip_rel   (rxbuf_ip_rel),
        .rxbuf_ip_grant (rxbuf_ip_grant),
        .rxbuf_wr       (rxbuf_wr),
        .led_r          (led_r),
        .led_g          (led_g),
        .led_b          (led_b)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // application data sharing
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    app_data_arbiter arb0 (
        .clk           (clk),
        .rst_n         (rst_n),
        .app_ip_req    (app_ip_req),
        .app_ip_rel    (app_ip_rel),
        .app_cpu_req   (app_cpu_req),
        .app_cpu_rel   (app_cpu_rel),
        .app_ip_grant  (app_ip_grant),
        .app_cpu_grant (app_cpu_grant)
    );

endmodule

/* tests/tb_checks.svh */
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
endfunction

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// reference model
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

function automatic word_t rom_word_ref(input txbuf_addr_t addr);
    word_t w;
    case (addr)
        6'd0:    w = TXMSG_WORD0;
        6'd1:    w = TXMSG_WORD1;
        6'd2:    w = TXMSG_WORD2;
        6'd3:    w = TXMSG_WORD3;
        6'd4:    w = TXMSG_WORD4;
        default: w = '0;
    endcase
    return w;
endfunction

// result is {r, g, b}
function automatic logic [2:0] led_colour_ref(input rx_size_t size);
    logic [2:0] led;
    led = 3'b001;
    if (size == '0) begin
        led = 3'b000;
    end else if (size <= LED_R_MAX) begin
        led = 3'b100;
    end else if (size <= LED_G_MAX) begin
        led = 3'b010;
    end
    return led;
endfunction

function automatic app_grant_t next_app_grant(input app_grant_t cur, input logic ip_req,
                                              input logic ip_rel, input logic cpu_req,
                                              input logic cpu_rel);
    app_grant_t nxt;
    nxt = cur;
    if (cur == GRANT_NONE) begin
        // a tie goes to the ip side
        nxt = ip_req ? GRANT_IP : (cpu_req ? GRANT_CPU : GRANT_NONE);
    end else if ((cur == GRANT_IP && ip_rel) || (cur == GRANT_CPU && cpu_rel)) begin
        nxt = GRANT_NONE;
    end
    return nxt;
endfunction

task automatic check_word(input word_t got, input word_t exp, input string what);
    if (got !== exp) begin
        $display("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp);
        abort_run();
    end
endtask

task automatic check_byte(input byte_t got, input byte_t exp, input string what);
    if (got !== exp) begin
        $display("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp);
        abort_run();
    end
endtask

task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp) begin
        $display("MISMATCH at %0t: %s got %b expected %b", $time, what, got, exp);
        abort_run();
    end
endtask

`endif

/* tests/tb_udp_cpu_shell.sv */
`timescale 1ns/1ps

module tb_udp_cpu_shell import shell_pkg::*; ();

    // about 800 cycles of stimulus in total
    localparam int TIMEOUT_CYCLES = 2000;
    // first grant 34 edges after reset release, then one every 33 edges
    localparam int FIRST_RISE     = 34;
    localparam int TX_PERIOD      = 33;

    logic        clk;
    logic        rst_n;
    logic        q_wr;
    byte_t       q_din;
    logic        q_full;
    logic        q_rd;
    byte_t       q_dout;
    logic        q_empty;
    logic        txbuf_ip_rel;
    logic        txbuf_ip_grant;
    txbuf_addr_t txbuf_addr;
    word_t       txbuf_rdata;
    logic        rxbuf_ip_rel;
    logic        rxbuf_ip_grant;
    rxbuf_wr_t   rxbuf_wr;
    logic        led_r;
    logic        led_g;
    logic        led_b;
    logic        app_ip_req;
    logic        app_ip_rel;
    logic        app_cpu_req;
    logic        app_cpu_rel;
    logic        app_ip_grant;
    logic        app_cpu_grant;

    byte_t       queue_model [$];
    logic        queue_was_full;
    rx_size_t    size_model;
    app_grant_t  app_model;
    logic [2:0]  led_exp;
    int          cycle_cnt = 0;
    logic [31:0] rng;
    logic        exp_bit;
    logic        want_wr;
    logic        want_rd;
    logic        saw_full;
    txbuf_addr_t rom_addr;

    udp_cpu_shell dut0 (.*);

    task automatic abort_run();
        $display("FAIL: see errors above");
        $fatal(1, "simulation stopped");
    endtask

    `include "tb_checks.svh"

    task automatic write_rxbuf(input rxbuf_addr_t addr, input logic we, input word_t data);
        @(posedge clk);
        rxbuf_wr.addr  <= addr;
        rxbuf_wr.ce    <= 1'b1;
        rxbuf_wr.we    <= we;
        rxbuf_wr.wdata <= data;
        @(posedge clk);
        rxbuf_wr       <= '0;
        @(negedge clk);
    endtask

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            abort_run();
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // model follows the inputs the DUT samples, compare runs on the falling edge
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always @(posedge clk) begin
        if (!rst_n) begin
            queue_model.delete();
            size_model = '0;
            app_model  = GRANT_NONE;
        end else begin
            queue_was_full = (queue_model.size() == RX_QUEUE_DEPTH);
            if (q_rd && queue_model.size() > 0) begin
                void'(queue_model.pop_front());
            end
            if (q_wr && !queue_was_full) begin
                queue_model.push_back(q_din);
            end
            if (rxbuf_wr.we && rxbuf_wr.addr == RX_SIZE_WORD_ADDR) begin
                size_model = rxbuf_wr.wdata[31:16];
            end
            app_model = next_app_grant(app_model, app_ip_req, app_ip_rel, app_cpu_req,
                                       app_cpu_rel);
        end
    end

    always @(negedge clk) begin
        if (rst_n) begin
            check_bit(app_ip_grant && app_cpu_grant, 1'b0, "both app grants high");
            check_bit(app_ip_grant, app_model == GRANT_IP, "app_ip_grant");
            check_bit(app_cpu_grant, app_model == GRANT_CPU, "app_cpu_grant");
            led_exp = led_colour_ref(size_model);
            check_bit(led_r, led_exp[2], "led_r");
            check_bit(led_g, led_exp[1], "led_g");
            check_bit(led_b, led_exp[0], "led_b");
            check_bit(q_empty, queue_model.size() == 0, "q_empty");
            check_bit(q_full, queue_model.size() == RX_QUEUE_DEPTH, "q_full");
            if (queue_model.size() > 0) begin
                check_byte(q_dout, queue_model[0], "q_dout head");
            end
        end
    end

    initial begin
        rst_n        = 1'b0;
        q_wr         = 1'b0;
        q_din        = '0;
        q_rd         = 1'b0;
        txbuf_ip_rel = 1'b0;
        txbuf_addr   = '0;
        rxbuf_ip_rel = 1'b0;
        rxbuf_wr     = '0;
        app_ip_req   = 1'b0;
        app_ip_rel   = 1'b0;
        app_cpu_req  = 1'b0;
        app_cpu_rel  = 1'b0;
        rng          = 32'd29213;
        saw_full     = 1'b0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;

        // transmit ownership, timed from the release edge
        @(negedge clk);
        check_bit(txbuf_ip_grant, 1'b0, "txbuf_ip_grant after reset");
        check_bit(rxbuf_ip_grant, 1'b1, "rxbuf_ip_grant after reset");
        check_word(txbuf_rdata, '0, "txbuf_rdata after reset");
        for (int k = 1; k <= FIRST_RISE + TX_PERIOD; k++) begin
            @(posedge clk);
            txbuf_ip_rel <= (k == FIRST_RISE + 1);
            @(negedge clk);
            exp_bit = (k == FIRST_RISE) || (k == FIRST_RISE + 1) ||
                      (k == FIRST_RISE + TX_PERIOD);
            check_bit(txbuf_ip_grant, exp_bit, "txbuf_ip_grant");
        end

        // message rom, the first addresses in order then random ones
        for (int i = 0; i < 40; i++) begin
            rng = xorshift32(rng);
            rom_addr = (i < 5) ? txbuf_addr_t'(i) : txbuf_addr_t'(rng[5:0]);
            @(posedge clk);
            txbuf_addr <= rom_addr;
            @(posedge clk);
            @(negedge clk);
            check_word(txbuf_rdata, rom_word_ref(rom_addr), "txbuf_rdata");
        end

        // receive ownership, low for two cycles after each release
        repeat (3) begin
            @(posedge clk);
            rxbuf_ip_rel <= 1'b1;
            for (int c = 0; c < 3; c++) begin
                @(posedge clk);
                rxbuf_ip_rel <= 1'b0;
                @(negedge clk);
                check_bit(rxbuf_ip_grant, c == 2, "rxbuf_ip_grant after release");
            end
        end

        // size capture, threshold edges first
        write_rxbuf(RX_SIZE_WORD_ADDR, 1'b1, {LED_R_MAX, 16'h1234});
        write_rxbuf(RX_SIZE_WORD_ADDR, 1'b1, {LED_R_MAX + 16'd1, 16'h0});
        write_rxbuf(RX_SIZE_WORD_ADDR, 1'b1, {LED_G_MAX, 16'h0});
        write_rxbuf(RX_SIZE_WORD_ADDR, 1'b1, {LED_G_MAX + 16'd1, 16'h0});
        write_rxbuf(RX_SIZE_WORD_ADDR, 1'b1, 32'h0000_ffff);
        for (int i = 0; i < 30; i++) begin
            rng = xorshift32(rng);
            write_rxbuf((rng[2:0] < 3'd5) ? RX_SIZE_WORD_ADDR : rxbuf_addr_t'(rng[13:8]),
                        rng[3] | rng[4], {11'd0, rng[20:16], rng[15:0]});
        end

        // tie goes to ip, cpu waits for the ip release
        @(posedge clk);
        app_ip_req  <= 1'b1;
        app_cpu_req <= 1'b1;
        @(posedge clk);
        app_ip_req  <= 1'b0;
        repeat (3) begin
            @(negedge clk);
            check_bit(app_ip_grant, 1'b1, "app_ip_grant on tie");
            check_bit(app_cpu_grant, 1'b0, "app_cpu_grant while ip holds");
        end
        @(posedge clk);
        app_ip_rel <= 1'b1;
        @(posedge clk);
        app_ip_rel <= 1'b0;
        @(posedge clk);
        @(negedge clk);
        check_bit(app_cpu_grant, 1'b1, "app_cpu_grant after ip release");
        repeat (40) begin
            rng = xorshift32(rng);
            @(posedge clk);
            app_ip_req  <= rng[0];
            app_cpu_req <= rng[1];
            app_ip_rel  <= rng[2];
            app_cpu_rel <= rng[3];
        end
        @(posedge clk);
        {app_ip_req, app_cpu_req, app_ip_rel, app_cpu_rel} <= 4'b0000;

        // byte queue, filling phase then draining phase
        for (int i = 0; i < 240; i++) begin
            @(negedge clk);
            rng = xorshift32(rng);
            want_wr = (i < 120) ? (rng[1:0] != 2'b00) : (rng[1:0] == 2'b00);
            want_rd = (i < 120) ? (rng[3:2] == 2'b00) : (rng[3:2] != 2'b00);
            saw_full = saw_full || (queue_model.size() == RX_QUEUE_DEPTH);
            @(posedge clk);
            q_wr  <= want_wr && (queue_model.size() < RX_QUEUE_DEPTH);
            q_rd  <= want_rd && (queue_model.size() > 0);
            q_din <= rng[15:8];
            @(posedge clk);
            q_wr  <= 1'b0;
            q_rd  <= 1'b0;
        end
        @(negedge clk);
        if (!saw_full) begin
            $display("byte queue stimulus never filled the queue");
            abort_run();
        end else begin
            $display("PASS: all tests");
            $finish;
        end
    end

endmodule

/* verilog.f */
+incdir+tests
src/shell_pkg.sv
src/byte_queue.sv
src/txbuf_msg_source.sv
src/rxbuf_monitor.sv
src/app_data_arbiter.sv
src/udp_cpu_shell.sv
tests/tb_udp_cpu_shell.sv
